/* Makefile */
TOP = tb_mpeg_sys_parser

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f flist.f

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

/* apb_regs.sv */
// apb register block
`timescale 1ns/1ns
`default_nettype none

module apb_regs #(
	parameter int MAX_STREAMS = 8
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  mpeg_sys_pkg::apb_addr_t paddr,
	input  mpeg_sys_pkg::apb_data_t pwdata,
	output mpeg_sys_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr,
	output logic                    parse_en,
	hdr_if.sink                     hdr
);
	import mpeg_sys_pkg::*;

	localparam int SLOT_W = (MAX_STREAMS > 1) ? $clog2(MAX_STREAMS) : 1;

	cnt_t      pack_cnt;
	cnt_t      sys_cnt;
	logic      access;   // apb access phase
	logic      hit;      // address is mapped
	logic      st_hit;
	apb_addr_t st_off;
	logic [SLOT_W-1:0] st_idx;

	assign access = psel && penable;
	assign pready = 1'b1; // zero wait states

	// stream table window
	assign st_off = paddr - STREAM_BASE;
	assign st_idx = st_off[SLOT_W+1:2];
	assign st_hit = (paddr >= STREAM_BASE) && (st_off < apb_addr_t'(4 * MAX_STREAMS)) &&
		(paddr[1:0] == 2'b00);

	always_comb begin
		prdata = '0;
		hit    = 1'b1;
		case (paddr)
			CTRL:       prdata = {31'd0, parse_en};
			STATUS:     prdata = {sys_cnt, pack_cnt};
			SCR_LO:     prdata = hdr.scr[31:0];
			SCR_HI:     prdata = {24'd0, hdr.scr[39:32]};
			MUX_RATE:   prdata = {8'd0, hdr.mux_rate};
			SYS_LEN:    prdata = {16'd0, hdr.sys_len};
			RATE_BOUND: prdata = {8'd0, hdr.rate_bound};
			FLAGS_RSVD: prdata = {8'd0, hdr.reserved, hdr.flags};
			default: begin
				if (st_hit) begin
					prdata = {15'd0, hdr.stream_valid[st_idx], hdr.stream_buf[st_idx]};
				end else begin
					hit = 1'b0;
				end
			end
		endcase
	end

	// only CTRL takes writes
	assign pslverr = access && (!hit || (pwrite && (paddr != CTRL)));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			parse_en <= 1'b0;
		end else if (access && pwrite && (paddr == CTRL)) begin
			parse_en <= pwdata[0];
		end
	end

	// header counters, wrap on overflow
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pack_cnt <= '0;
			sys_cnt  <= '0;
		end else begin
			if (hdr.pack_done) begin
				pack_cnt <= pack_cnt + 16'd1;
			end
			if (hdr.sys_done) begin
				sys_cnt <= sys_cnt + 16'd1;
			end
		end
	end

endmodule

`default_nettype wire

/* bit_deserializer.sv */
// serial to byte packer
`timescale 1ns/1ns
`default_nettype none

module bit_deserializer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                bit_en,
	input  logic                bit_in,
	output mpeg_sys_pkg::byte_t byte_data,
	output logic                byte_valid
);

	logic [2:0] bit_cnt; // position inside the current byte

	// byte phase counter and strobe
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			bit_cnt    <= 3'd0;
			byte_valid <= 1'b0;
		end else begin
			byte_valid <= bit_en && (bit_cnt == 3'd7); // eighth bit sampled now
			if (bit_en) begin
				bit_cnt <= bit_cnt + 3'd1; // wraps on the byte boundary
			end
		end
	end

	// lsb first, new bit enters at the top
	always_ff @(posedge clk) begin
		if (bit_en) begin
			byte_data <= {bit_in, byte_data[7:1]};
		end
	end

endmodule

`default_nettype wire

/* flist.f */
mpeg_sys_pkg.sv
hdr_if.sv
bit_deserializer.sv
start_code_detect.sv
pack_header_parser.sv
system_header_parser.sv
apb_regs.sv
mpeg_sys_parser.sv
tb_clk_gen.sv
tb_mpeg_sys_parser.sv

/* hdr_if.sv */
// published header fields
`timescale 1ns/1ns
`default_nettype none

interface hdr_if #(
	parameter int MAX_STREAMS = 8
);
	import mpeg_sys_pkg::*;

	// pack header side
	scr_t   scr;
	rate_t  mux_rate;
	logic   pack_done;

	// system header side
	len_t   sys_len;
	rate_t  rate_bound;
	flags_t flags;
	byte_t  reserved;
	buf_t   stream_buf [MAX_STREAMS];
	logic   [MAX_STREAMS-1:0] stream_valid;
	logic   sys_done;

	modport pack_src (output scr, mux_rate, pack_done);
	modport sys_src (output sys_len, rate_bound, flags, reserved, stream_buf, stream_valid,
		sys_done);
	modport sink (input scr, mux_rate, pack_done, sys_len, rate_bound, flags, reserved,
		stream_buf, stream_valid, sys_done);

endinterface

`default_nettype wire

/* mpeg_sys_parser.sv */
// mpeg system layer receiver
`timescale 1ns/1ns
`default_nettype none

module mpeg_sys_parser #(
	parameter int MAX_STREAMS = 8
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    bit_en,
	input  logic                    bit_in,
	input  logic                    psel,
	input  logic                    penable,
	input  logic                    pwrite,
	input  mpeg_sys_pkg::apb_addr_t paddr,
	input  mpeg_sys_pkg::apb_data_t pwdata,
	output mpeg_sys_pkg::apb_data_t prdata,
	output logic                    pready,
	output logic                    pslverr
);
	import mpeg_sys_pkg::*;

	byte_t byte_data;
	logic  byte_valid;
	byte_t code;
	logic  code_valid;
	logic  parse_en;
	logic  bit_en_g;   // bits gated by CTRL enable

	assign bit_en_g = bit_en && parse_en;

	hdr_if #(.MAX_STREAMS(MAX_STREAMS)) hdr ();

	bit_deserializer u_deser (
		.clk, .rst_n, .bit_en(bit_en_g), .bit_in, .byte_data, .byte_valid
	);

	start_code_detect u_detect (
		.clk, .rst_n, .byte_data, .byte_valid, .code, .code_valid
	);

	pack_header_parser u_pack (
		.clk, .rst_n, .byte_data, .byte_valid, .code, .code_valid, .hdr(hdr.pack_src)
	);

	system_header_parser #(.MAX_STREAMS(MAX_STREAMS)) u_sys (
		.clk, .rst_n, .byte_data, .byte_valid, .code, .code_valid, .hdr(hdr.sys_src)
	);

	apb_regs #(.MAX_STREAMS(MAX_STREAMS)) u_regs (
		.clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr, .parse_en, .hdr(hdr.sink)
	);

endmodule

`default_nettype wire

/* mpeg_sys_pkg.sv */
// mpeg system layer definitions
`default_nettype none

package mpeg_sys_pkg;

	// widths with a meaning
	typedef logic [7:0]  byte_t;     // one stream byte
	typedef logic [39:0] scr_t;      // raw scr field with markers
	typedef logic [23:0] rate_t;     // mux rate or rate bound
	typedef logic [15:0] len_t;      // system header length
	typedef logic [15:0] flags_t;    // audio/video bounds and flags
	typedef logic [15:0] buf_t;      // stream buffer field
	typedef logic [15:0] cnt_t;      // header counter
	typedef logic [7:0]  apb_addr_t;
	typedef logic [31:0] apb_data_t;

	// start code bytes after the 00 00 01 prefix
	localparam byte_t pack_code = 8'hba;
	localparam byte_t sys_code  = 8'hbb;

	// fixed system header bytes counted by the length field
	localparam len_t sys_fixed_len = 16'd6;

	// register map, word offsets
	localparam apb_addr_t CTRL        = 8'h00;
	localparam apb_addr_t STATUS      = 8'h04;
	localparam apb_addr_t SCR_LO      = 8'h08;
	localparam apb_addr_t SCR_HI      = 8'h0c;
	localparam apb_addr_t MUX_RATE    = 8'h10;
	localparam apb_addr_t SYS_LEN     = 8'h14;
	localparam apb_addr_t RATE_BOUND  = 8'h18;
	localparam apb_addr_t FLAGS_RSVD  = 8'h1c;
	localparam apb_addr_t STREAM_BASE = 8'h20; // eight words up to 0x3c

	// header parser states, the pack parser never enters ENTRIES
	typedef enum logic [1:0] {
		IDLE,
		HEADER,
		ENTRIES
	} parse_state_t;

endpackage

`default_nettype wire

/* pack_header_parser.sv */
// pack header parser
`timescale 1ns/1ns
`default_nettype none

module pack_header_parser (
	input  logic                clk,
	input  logic                rst_n,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                byte_valid,
	input  mpeg_sys_pkg::byte_t code,
	input  logic                code_valid,
	hdr_if.pack_src             hdr
);
	import mpeg_sys_pkg::*;

	parse_state_t state;
	logic [2:0]   byte_cnt;  // header byte index
	logic [63:0]  work;      // scr then mux rate, first byte on top
	logic [63:0]  work_next;
	logic         last_byte;

	assign work_next = {work[55:0], byte_data};
	assign last_byte = (state == HEADER) && byte_valid && (byte_cnt == 3'd7);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= IDLE;
			byte_cnt <= 3'd0;
		end else begin
			case (state)
				IDLE: begin
					if (code_valid && (code == pack_code)) begin
						state    <= HEADER;
						byte_cnt <= 3'd0;
					end
				end
				HEADER: begin
					if (byte_valid) begin
						byte_cnt <= byte_cnt + 3'd1;
						if (byte_cnt == 3'd7) begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == HEADER) && byte_valid) begin
			work <= work_next;
		end
	end

	// published fields, held until the next pack header
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hdr.pack_done <= 1'b0;
			hdr.scr       <= '0;
			hdr.mux_rate  <= '0;
		end else begin
			hdr.pack_done <= last_byte;
			if (last_byte) begin
				hdr.scr      <= work_next[63:24];
				hdr.mux_rate <= work_next[23:0];
			end
		end
	end

endmodule

`default_nettype wire

/* start_code_detect.sv */
// start code prefix detector
`timescale 1ns/1ns
`default_nettype none

module start_code_detect (
	input  logic                clk,
	input  logic                rst_n,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                byte_valid,
	output mpeg_sys_pkg::byte_t code,
	output logic                code_valid
);

	typedef enum logic [1:0] {
		S_NONE,   // no prefix byte yet
		S_ZERO1,  // one 00 seen
		S_ZERO2,  // 00 00 seen
		S_PREFIX  // next byte is the code
	} det_state_t;

	det_state_t state;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= S_NONE;
			code_valid <= 1'b0;
		end else begin
			code_valid <= 1'b0;
			if (byte_valid) begin
				case (state)
					S_NONE:  state <= (byte_data == 8'h00) ? S_ZERO1 : S_NONE;
					S_ZERO1: state <= (byte_data == 8'h00) ? S_ZERO2 : S_NONE;
					S_ZERO2: begin
						if (byte_data == 8'h01) begin
							state <= S_PREFIX;
						end else if (byte_data != 8'h00) begin // extra zeros keep the prefix open
							state <= S_NONE;
						end
					end
					S_PREFIX: begin
						code_valid <= 1'b1; // any code byte is reported
						state      <= (byte_data == 8'h00) ? S_ZERO1 : S_NONE;
					end
					default: state <= S_NONE;
				endcase
			end
		end
	end

	// code byte valid with code_valid
	always_ff @(posedge clk) begin
		if (byte_valid && (state == S_PREFIX)) begin
			code <= byte_data;
		end
	end

endmodule

`default_nettype wire

/* system_header_parser.sv */
// system header parser
`timescale 1ns/1ns
`default_nettype none

module system_header_parser #(
	parameter int MAX_STREAMS = 8
) (
	input  logic                clk,
	input  logic                rst_n,
	input  mpeg_sys_pkg::byte_t byte_data,
	input  logic                byte_valid,
	input  mpeg_sys_pkg::byte_t code,
	input  logic                code_valid,
	hdr_if.sys_src              hdr
);
	import mpeg_sys_pkg::*;

	localparam int SLOT_W = (MAX_STREAMS > 1) ? $clog2(MAX_STREAMS) : 1;

	parse_state_t state;
	logic [2:0]   hdr_cnt;   // fixed byte index
	logic [1:0]   ent_cnt;   // id, buf hi, buf lo
	len_t         rem;       // bytes left in the header
	logic [63:0]  work;      // len, rate bound, flags, reserved
	logic [63:0]  fix_cur;
	len_t         fix_len;
	logic         ent_byte;
	logic         finish;
	logic [SLOT_W-1:0] slot;
	byte_t        buf_hi;
	buf_t         tbl_w [MAX_STREAMS];
	buf_t         tbl_next [MAX_STREAMS];
	logic [MAX_STREAMS-1:0] vld_w;
	logic [MAX_STREAMS-1:0] vld_next;

	assign fix_cur  = ((state == HEADER) && byte_valid) ? {work[55:0], byte_data} : work;
	assign fix_len  = fix_cur[63:48];
	assign ent_byte = (state == ENTRIES) && byte_valid;
	assign finish   = byte_valid &&
		(((state == HEADER) && (hdr_cnt == 3'd7) && (fix_len <= sys_fixed_len)) ||
		((state == ENTRIES) && (rem == 16'd1)));

	// table with the current entry merged in
	always_comb begin
		tbl_next = tbl_w;
		vld_next = vld_w;
		if (ent_byte && (ent_cnt == 2'd2)) begin
			tbl_next[slot] = {buf_hi, byte_data};
			vld_next[slot] = 1'b1; // later entries overwrite
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state   <= IDLE;
			hdr_cnt <= 3'd0;
			ent_cnt <= 2'd0;
			rem     <= '0;
			vld_w   <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (code_valid && (code == sys_code)) begin
						state   <= HEADER;
						hdr_cnt <= 3'd0;
						vld_w   <= '0; // fresh table per header
					end
				end
				HEADER: begin
					if (byte_valid) begin
						hdr_cnt <= hdr_cnt + 3'd1;
						if (hdr_cnt == 3'd7) begin
							ent_cnt <= 2'd0;
							rem     <= fix_len - sys_fixed_len;
							state   <= finish ? IDLE : ENTRIES;
						end
					end
				end
				ENTRIES: begin
					if (byte_valid) begin
						rem     <= rem - 16'd1;
						vld_w   <= vld_next;
						ent_cnt <= (ent_cnt == 2'd2) ? 2'd0 : ent_cnt + 2'd1;
						if (finish) begin
							state <= IDLE;
						end
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		work  <= fix_cur;
		tbl_w <= tbl_next;
		if (ent_byte && (ent_cnt == 2'd0)) begin
			slot <= byte_data[SLOT_W-1:0]; // low bits of stream id
		end
		if (ent_byte && (ent_cnt == 2'd1)) begin
			buf_hi <= byte_data;
		end
	end

	// publish with sys_done, empty slots read zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			hdr.sys_done     <= 1'b0;
			hdr.sys_len      <= '0;
			hdr.rate_bound   <= '0;
			hdr.flags        <= '0;
			hdr.reserved     <= '0;
			hdr.stream_valid <= '0;
			hdr.stream_buf   <= '{default: '0};
		end else begin
			hdr.sys_done <= finish;
			if (finish) begin
				hdr.sys_len      <= fix_len;
				hdr.rate_bound   <= fix_cur[47:24];
				hdr.flags        <= fix_cur[23:8];
				hdr.reserved     <= fix_cur[7:0];
				hdr.stream_valid <= vld_next;
				for (int i = 0; i < MAX_STREAMS; i++) begin
					hdr.stream_buf[i] <= vld_next[i] ? tbl_next[i] : '0;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// testbench clock source
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD = 4
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
	end

	always #(PERIOD / 2) clk = ~clk; // half period each phase

endmodule

`default_nettype wire

/* tb_mpeg_sys_parser.sv */
// mpeg system parser testbench
`timescale 1ns/1ns
`default_nettype none

module tb_mpeg_sys_parser;
	import mpeg_sys_pkg::*;

	logic        clk;
	logic        rst_n;
	logic        bit_en;
	logic        bit_in;
	logic        psel;
	logic        penable;
	logic        pwrite;
	apb_addr_t   paddr;
	apb_data_t   pwdata;
	apb_data_t   prdata;
	logic        pready;
	logic        pslverr;

	logic [31:0] rnd_state;
	int          errors;
	int          test_err;   // error count when the test began
	int          tests;
	byte_t       hq[$];      // bytes waiting to be serialized
	apb_data_t   rd;
	logic        rerr;
	apb_addr_t   a;
	int          n;
	scr_t        exp_scr;
	rate_t       exp_mux;
	len_t        exp_len;
	rate_t       exp_bound;
	flags_t      exp_flags;
	byte_t       exp_rsvd;
	buf_t        exp_buf [8];
	logic [7:0]  exp_vld;
	cnt_t        pack_cnt;
	cnt_t        sys_cnt;
	scr_t        keep_scr;
	rate_t       keep_mux;

	tb_clk_gen #(.PERIOD(4)) u_clk (.clk);

	mpeg_sys_parser #(.MAX_STREAMS(8)) DUT (
		.clk, .rst_n, .bit_en, .bit_in, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr
	);

	function automatic logic [31:0] next_rand();
		rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
		return rnd_state;
	endfunction

	function automatic byte_t rand_byte();
		logic [31:0] r;
		r = next_rand();
		return r[31:24]; // top byte of the state
	endfunction

	function automatic int rand_range(input int lim);
		logic [31:0] r;
		r = next_rand();
		return int'(r[31:16]) % lim;
	endfunction

	task automatic abort_run(input string what);
		$display("timeout: %s", what);
		$display("TEST RESULT: FAIL");
		$finish;
	endtask

	task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_scr(input string name, input scr_t got, input scr_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_rate(input string name, input rate_t got, input rate_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_len(input string name, input len_t got, input len_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flags(input string name, input flags_t got, input flags_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_buf(input string name, input buf_t got, input buf_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_cnt(input string name, input cnt_t got, input cnt_t exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("ERR %s got=%h exp=%h", name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		$display("test %0d %s: %s", tests, name, (errors == test_err) ? "ok" : "errors");
		tests++;
		test_err = errors;
	endtask

	// one apb transfer sampled mid access cycle
	task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
		output apb_data_t rdata, output logic err);
		int t;
		t = 0;
		@(posedge clk);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= wr;
		paddr   <= addr;
		pwdata  <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		while (!pready) begin
			t++;
			if (t > 20) begin
				abort_run("pready stayed low during an APB access");
			end
			@(negedge clk);
		end
		rdata = prdata;
		err   = pslverr;
		@(posedge clk);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
		apb_xfer(1'b0, addr, '0, data, err);
	endtask

	task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
		apb_data_t ignored;
		apb_xfer(1'b1, addr, data, ignored, err);
	endtask

	// lsb first with bit_en high about 70 percent
	task automatic send_byte(input byte_t b);
		int i;
		int t;
		logic en;
		i = 0;
		t = 0;
		while (i < 8) begin
			@(posedge clk);
			en = rand_range(100) < 70;
			bit_en <= en;
			bit_in <= b[i];
			if (en) begin
				i++;
			end
			t++;
			if (t > 400) begin
				abort_run("serial bits stopped advancing");
			end
		end
	endtask

	task automatic send_queue();
		while (hq.size() > 0) begin
			send_byte(hq.pop_front());
		end
		@(posedge clk);
		bit_en <= 1'b0;
	endtask

	// never 00 or 01 so no prefix forms
	task automatic add_filler(input int cnt);
		byte_t b;
		for (int k = 0; k < cnt; k++) begin
			b = rand_byte();
			hq.push_back((b < 8'h02) ? 8'hff : b);
		end
	endtask

	task automatic add_prefix(input byte_t c);
		hq.push_back(8'h00);
		hq.push_back(8'h00);
		hq.push_back(8'h01);
		hq.push_back(c);
	endtask

	task automatic pack_header();
		byte_t b [8];
		for (int k = 0; k < 8; k++) begin
			b[k] = rand_byte();
		end
		exp_scr = {b[0], b[1], b[2], b[3], b[4]}; // first byte on top
		exp_mux = {b[5], b[6], b[7]};
		add_filler(1 + rand_range(4));
		if (rand_range(2) == 0) begin
			hq.push_back(8'h00); // extra zero ahead of the prefix
		end
		add_prefix(pack_code);
		for (int k = 0; k < 8; k++) begin
			hq.push_back(b[k]);
		end
		add_filler(2);
		send_queue();
	endtask

	task automatic sys_header(input int entries);
		byte_t id;
		buf_t  bv;
		exp_len   = len_t'(6 + 3 * entries);
		exp_bound = {rand_byte(), rand_byte(), rand_byte()};
		exp_flags = {rand_byte(), rand_byte()};
		exp_rsvd  = rand_byte();
		exp_vld   = '0; // table starts empty each header
		for (int k = 0; k < 8; k++) begin
			exp_buf[k] = '0;
		end
		add_filler(1 + rand_range(4));
		add_prefix(sys_code);
		hq.push_back(exp_len[15:8]);
		hq.push_back(exp_len[7:0]);
		hq.push_back(exp_bound[23:16]);
		hq.push_back(exp_bound[15:8]);
		hq.push_back(exp_bound[7:0]);
		hq.push_back(exp_flags[15:8]);
		hq.push_back(exp_flags[7:0]);
		hq.push_back(exp_rsvd);
		for (int k = 0; k < entries; k++) begin
			id = 8'hc0 | byte_t'(rand_range(16));
			bv = {rand_byte(), rand_byte()};
			exp_buf[id[2:0]] = bv; // last write wins
			exp_vld[id[2:0]] = 1'b1;
			hq.push_back(id);
			hq.push_back(bv[15:8]);
			hq.push_back(bv[7:0]);
		end
		add_filler(2);
		send_queue();
	endtask

	task automatic wait_count(input logic sys, input cnt_t old);
		int   t;
		cnt_t c;
		t = 0;
		c = old;
		while (c == old) begin
			t++;
			if (t > 40) begin
				abort_run("header counter in STATUS never changed");
			end
			apb_read(STATUS, rd, rerr);
			c = sys ? rd[31:16] : rd[15:0];
		end
	endtask

	task automatic check_counts();
		apb_read(STATUS, rd, rerr);
		check_cnt("pack_cnt", rd[15:0], pack_cnt);
		check_cnt("sys_cnt", rd[31:16], sys_cnt);
	endtask

	task automatic check_pack();
		apb_data_t lo;
		apb_read(SCR_LO, lo, rerr);
		apb_read(SCR_HI, rd, rerr);
		check_scr("scr", {rd[7:0], lo}, exp_scr);
		apb_read(MUX_RATE, rd, rerr);
		check_rate("mux_rate", rd[23:0], exp_mux);
		check_counts();
	endtask

	task automatic check_sys();
		apb_addr_t addr;
		apb_read(SYS_LEN, rd, rerr);
		check_len("sys_len", rd[15:0], exp_len);
		apb_read(RATE_BOUND, rd, rerr);
		check_rate("rate_bound", rd[23:0], exp_bound);
		apb_read(FLAGS_RSVD, rd, rerr);
		check_flags("flags", rd[15:0], exp_flags);
		check_byte("reserved", rd[23:16], exp_rsvd);
		addr = STREAM_BASE;
		for (int k = 0; k < 8; k++) begin
			apb_read(addr, rd, rerr);
			check_buf($sformatf("stream_buf[%0d]", k), rd[15:0], exp_buf[k]);
			check_bit($sformatf("stream_valid[%0d]", k), rd[16], exp_vld[k]);
			addr = addr + 8'd4;
		end
		check_counts();
	endtask

	initial begin
		rst_n   <= 1'b0;
		bit_en  <= 1'b0;
		bit_in  <= 1'b0;
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= '0;
		pwdata  <= '0;
		rnd_state = 32'd81046;
		errors    = 0;
		test_err  = 0;
		tests     = 1;
		pack_cnt  = '0;
		sys_cnt   = '0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		a = CTRL;
		for (int k = 0; k < 16; k++) begin
			apb_read(a, rd, rerr);
			check_word($sformatf("reg %02h", a), rd, '0);
			a = a + 8'd4;
		end
		apb_write(CTRL, 32'd1, rerr);
		check_bit("pslverr", rerr, 1'b0);
		apb_read(CTRL, rd, rerr);
		check_word("ctrl", rd, 32'd1);
		end_test("reset values and enable");

		for (int k = 0; k < 10; k++) begin
			pack_header();
			wait_count(1'b0, pack_cnt);
			pack_cnt = pack_cnt + 16'd1;
			check_pack();
		end
		end_test("pack headers");

		for (int k = 0; k < 6; k++) begin
			n = (k == 0) ? 1 : (k == 1) ? 8 : 1 + rand_range(8);
			sys_header(n);
			wait_count(1'b1, sys_cnt);
			sys_cnt = sys_cnt + 16'd1;
			check_sys();
		end
		end_test("system headers");

		// near misses and a foreign code
		add_filler(2);
		hq.push_back(8'h00);
		hq.push_back(8'h00);
		hq.push_back(8'h02);
		add_filler(1);
		hq.push_back(8'h00);
		hq.push_back(8'h01);
		hq.push_back(pack_code);
		add_filler(1);
		add_prefix(8'hc0);
		add_filler(3);
		send_queue();
		check_pack();
		check_sys();
		end_test("false prefixes");

		apb_write(CTRL, 32'd0, rerr);
		keep_scr = exp_scr;
		keep_mux = exp_mux;
		pack_header();
		exp_scr = keep_scr; // ignored header leaves fields alone
		exp_mux = keep_mux;
		check_pack();
		apb_write(CTRL, 32'd1, rerr);
		pack_header();
		wait_count(1'b0, pack_cnt);
		pack_cnt = pack_cnt + 16'd1;
		check_pack();
		end_test("enable gating");

		apb_read(8'h40, rd, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_read(8'h02, rd, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_read(8'hfc, rd, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_write(STATUS, 32'hffff_ffff, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_write(SCR_LO, 32'h1234_5678, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_write(STREAM_BASE, 32'h0001_ffff, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_write(8'h80, 32'd0, rerr);
		check_bit("pslverr", rerr, 1'b1);
		apb_read(CTRL, rd, rerr);
		check_word("ctrl", rd, 32'd1);
		check_bit("pslverr", rerr, 1'b0);
		check_pack();
		check_sys();
		end_test("slave errors");

		$display("tests %0d errors %0d", tests - 1, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
